//--- include/lz_macros.svh
`ifndef LZ_MACROS_SVH
`define LZ_MACROS_SVH

// block geometry
`define LZ_BLOCK_DEPTH 256 // bytes per block and history
`define LZ_POS_BITS 8      // position width inside a block

// match limits
`define LZ_MAX_MATCH 15    // longest copy, fits the 4-bit length
`define LZ_MIN_MATCH 3     // shorter matches go out as literals

// hash table index width
`define LZ_HASH_BITS 8

// tokens the consumer can hold after reset
`define LZ_CREDITS 4

`endif

//--- rtl/lzPkg.sv
`include "lz_macros.svh"

package lzPkg;

  typedef logic [`LZ_POS_BITS-1:0] lzPos_t;    // byte index in block
  typedef logic [3:0] lzLen_t;                 // match length 0..15
  typedef logic [`LZ_POS_BITS-1:0] lzOffset_t; // distance back to match

  // controller sequence, one token at a time
  typedef enum logic [2:0] {
    sIdle,    // waiting for first byte of a block
    sLoad,    // filling the history
    sLookup,  // hash lookup at current position
    sCompare, // comparator running
    sEmit,    // token waits for credit
    sAdvance, // step position by token length
    sDone     // blockDone pulse
  } ctrlState_t;

endpackage

//--- rtl/historyBuffer.sv
`include "lz_macros.svh"

module historyBuffer import lzPkg::*; (
  input  logic            clock,
  input  logic            arstN,
  input  logic            wrEn,
  input  lzPos_t          wrAddr,
  input  logic [7:0]      wrData,
  input  lzPos_t          winAddr,
  input  lzPos_t          cmpAddrA,
  input  lzPos_t          cmpAddrB,
  output logic [2:0][7:0] winBytes,
  output logic [7:0]      cmpByteA,
  output logic [7:0]      cmpByteB
);

  logic [7:0] mem [`LZ_BLOCK_DEPTH]; // block bytes

  always_ff @(posedge clock) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData; // loader writes in order
    end
  end

  // hash window wraps at 255 where the controller never hashes
  assign winBytes[0] = mem[winAddr];
  assign winBytes[1] = mem[winAddr + lzPos_t'(1)];
  assign winBytes[2] = mem[winAddr + lzPos_t'(2)];

  // comparator read views
  assign cmpByteA = mem[cmpAddrA]; // current side
  assign cmpByteB = mem[cmpAddrB]; // candidate side

  // compare addresses only move while the block is parsed,
  // so the history must be stable by then
  aNoWriteWhileComparing : assert property (
    @(posedge clock) disable iff (!arstN)
    (!$stable(cmpAddrA) || !$stable(cmpAddrB)) |-> !wrEn
  );

endmodule

//--- rtl/hashTable.sv
`include "lz_macros.svh"

module hashTable import lzPkg::*; (
  input  logic            clock,
  input  logic            arstN,
  input  logic            clearAll,
  input  logic [2:0][7:0] window,
  input  logic            insert,
  input  lzPos_t          insertPos,
  output logic            hit,
  output lzPos_t          candidate
);

  localparam int TableSize = 1 << `LZ_HASH_BITS;

  logic [7:0]               mix;              // xor of the three bytes
  logic [`LZ_HASH_BITS-1:0] idx;              // table index
  lzPos_t                   posMem [TableSize]; // last position per hash
  logic [TableSize-1:0]     valid;            // written in this block

  assign mix = window[0] ^ window[1] ^ window[2];
  assign idx = mix[`LZ_HASH_BITS-1:0];

  // lookup, combinational
  assign hit       = valid[idx];
  assign candidate = posMem[idx];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      valid <= '0;
    end else if (clearAll) begin
      valid <= '0;              // new block forgets old positions
    end else if (insert) begin
      valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (insert) begin
      posMem[idx] <= insertPos; // newest position wins
    end
  end

  // positions are inserted in rising order within a block
  aCandidateBehind : assert property (
    @(posedge clock) disable iff (!arstN)
    (insert && hit) |-> (candidate < insertPos)
  );

endmodule

//--- rtl/matchComparator.sv
`include "lz_macros.svh"

module matchComparator import lzPkg::*; (
  input  logic                  clock,
  input  logic                  arstN,
  input  logic                  start,
  input  lzPos_t                curPos,
  input  lzPos_t                candPos,
  input  logic [`LZ_POS_BITS:0] blockLen, // 1..256
  input  logic [7:0]            cmpByteA,
  input  logic [7:0]            cmpByteB,
  output lzPos_t                addrA,
  output lzPos_t                addrB,
  output logic                  busy,
  output logic                  finished,
  output lzLen_t                matchLen
);

  lzLen_t                count;    // bytes matched so far
  logic [`LZ_POS_BITS:0] curSum;   // curPos + count without wrap
  logic                  keepGoing;

  assign addrA  = curPos + lzPos_t'(count);
  assign addrB  = candPos + lzPos_t'(count);
  assign curSum = {1'b0, curPos} + {{(`LZ_POS_BITS-3){1'b0}}, count};

  // step while bytes agree, under the cap, inside the block
  assign keepGoing = busy && (cmpByteA == cmpByteB)
                     && (count < lzLen_t'(`LZ_MAX_MATCH))
                     && (curSum < blockLen);

  assign finished = busy && !keepGoing; // last compare cycle
  assign matchLen = count;

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      count <= '0;         // fresh match
    end else if (keepGoing) begin
      count <= count + lzLen_t'(1);
    end else if (busy) begin
      busy <= 1'b0;        // count holds the result
    end
  end

  // a match never runs past the end of the block
  aInsideBlock : assert property (
    @(posedge clock) disable iff (!arstN)
    busy |-> (curSum <= blockLen)
  );

endmodule

//--- rtl/creditCounter.sv
`include "lz_macros.svh"

module creditCounter (
  input  logic clock,
  input  logic arstN,
  input  logic spend,
  input  logic creditReturn,
  output logic haveCredit
);

  localparam int CntBits = $clog2(`LZ_CREDITS + 1);

  logic [CntBits-1:0] credits; // tokens the consumer can still take

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      credits <= CntBits'(`LZ_CREDITS); // full after reset
    end else begin
      case ({spend, creditReturn})
        2'b10:   credits <= credits - CntBits'(1);
        2'b01:   credits <= credits + CntBits'(1);
        default: credits <= credits; // both or neither
      endcase
    end
  end

  assign haveCredit = (credits != '0);

  aNoSpendAtZero : assert property (
    @(posedge clock) disable iff (!arstN)
    spend |-> (credits != '0)
  );

  // consumer must not hand back more than it got
  aNoOverReturn : assert property (
    @(posedge clock) disable iff (!arstN)
    credits <= CntBits'(`LZ_CREDITS)
  );

endmodule

//--- rtl/matchController.sv
`include "lz_macros.svh"

module matchController import lzPkg::*; (
  input  logic                  clock,
  input  logic                  arstN,
  input  logic                  inValid,
  input  logic [7:0]            inByte,
  input  logic                  inLast,
  input  logic [7:0]            curByte, // history byte at curPos
  input  logic                  hit,
  input  lzPos_t                candidate,
  input  logic                  finished,
  input  lzLen_t                matchLen,
  input  logic                  haveCredit,
  output logic                  inReady,
  output logic                  wrEn,
  output lzPos_t                wrAddr,
  output logic [7:0]            wrData,
  output lzPos_t                curPos,
  output logic                  insert,
  output logic                  clearAll,
  output logic                  start,
  output lzPos_t                candPos,
  output logic [`LZ_POS_BITS:0] blockLen,
  output logic                  spend,
  output logic                  tokenValid,
  output logic                  tokenIsCopy,
  output logic [7:0]            tokenLiteral,
  output lzOffset_t             tokenOffset,
  output lzLen_t                tokenLength,
  output logic                  blockDone
);

  ctrlState_t            state;
  logic [`LZ_POS_BITS:0] lenCnt;   // bytes loaded so far
  logic [`LZ_POS_BITS:0] nextPos;  // position after current token
  logic                  accept;   // byte handshake
  logic                  lastByte; // inLast or history full
  logic                  canHash;  // p+2 inside the block
  logic                  lastTok;

  assign accept   = inValid && inReady;
  assign lastByte = inLast || (lenCnt == (`LZ_POS_BITS+1)'(`LZ_BLOCK_DEPTH - 1));
  assign canHash  = ({1'b0, curPos} + (`LZ_POS_BITS+1)'(2)) < blockLen;
  assign nextPos  = {1'b0, curPos} + {{(`LZ_POS_BITS-3){1'b0}}, tokenLength};
  assign lastTok  = nextPos >= blockLen;

  assign blockLen = lenCnt;

  // history write straight from the input port
  assign wrEn   = accept;
  assign wrAddr = lenCnt[`LZ_POS_BITS-1:0];
  assign wrData = inByte;

  always_comb begin
    inReady    = (state == sIdle) || (state == sLoad);
    clearAll   = (state == sIdle) && accept;        // table reset at block start
    insert     = (state == sLookup) && canHash;     // every token start
    start      = (state == sLookup) && canHash && hit;
    tokenValid = (state == sEmit) && haveCredit;    // one cycle per token
    spend      = tokenValid;
    blockDone  = (state == sDone);
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state        <= sIdle;
      lenCnt       <= '0;
      curPos       <= '0;
      candPos      <= '0;
      tokenIsCopy  <= 1'b0;
      tokenLiteral <= '0;
      tokenOffset  <= '0;
      tokenLength  <= '0;
    end else begin
      case (state)
        sIdle, sLoad: begin
          if (accept) begin
            lenCnt <= lenCnt + (`LZ_POS_BITS+1)'(1);
            state  <= lastByte ? sLookup : sLoad;
          end
        end
        sLookup: begin
          candPos      <= candidate;  // table changes after insert
          tokenIsCopy  <= 1'b0;       // literal unless compare says so
          tokenLiteral <= curByte;
          tokenOffset  <= '0;
          tokenLength  <= lzLen_t'(1);
          state        <= (canHash && hit) ? sCompare : sEmit;
        end
        sCompare: begin
          if (finished) begin
            if (matchLen >= lzLen_t'(`LZ_MIN_MATCH)) begin
              tokenIsCopy  <= 1'b1;
              tokenLiteral <= '0;
              tokenOffset  <= curPos - candPos;
              tokenLength  <= matchLen;
            end
            state <= sEmit;
          end
        end
        sEmit: begin
          if (haveCredit) begin   // otherwise hold, token stays put
            if (lastTok) begin
              curPos <= '0;       // parked before next load
              state  <= sDone;
            end else begin
              state <= sAdvance;
            end
          end
        end
        sAdvance: begin
          curPos <= nextPos[`LZ_POS_BITS-1:0];
          state  <= sLookup;
        end
        sDone: begin
          lenCnt <= '0;
          state  <= sIdle;
        end
        default: state <= sIdle;
      endcase
    end
  end

endmodule

//--- rtl/compressorTop.sv
`include "lz_macros.svh"

module compressorTop import lzPkg::*; (
  input  logic       clock,
  input  logic       arstN,
  input  logic       inValid,
  input  logic [7:0] inByte,
  input  logic       inLast,
  output logic       inReady,
  output logic       tokenValid,
  output logic       tokenIsCopy,
  output logic [7:0] tokenLiteral,
  output lzOffset_t  tokenOffset,
  output lzLen_t     tokenLength,
  input  logic       creditReturn,
  output logic       blockDone
);

  logic                  wrEn;
  lzPos_t                wrAddr;
  logic [7:0]            wrData;
  lzPos_t                curPos;
  lzPos_t                candPos;
  lzPos_t                addrA;
  lzPos_t                addrB;
  logic [2:0][7:0]       winBytes;  // hash window at curPos
  logic [7:0]            cmpByteA;
  logic [7:0]            cmpByteB;
  logic                  clearAll;
  logic                  insert;
  logic                  hit;
  lzPos_t                candidate;
  logic                  start;
  logic                  finished;
  lzLen_t                matchLen;
  logic [`LZ_POS_BITS:0] blockLen;
  logic                  spend;
  logic                  haveCredit;

  historyBuffer i_historyBuffer (
    .clock    (clock),
    .arstN    (arstN),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .wrData   (wrData),
    .winAddr  (curPos),
    .cmpAddrA (addrA),
    .cmpAddrB (addrB),
    .winBytes (winBytes),
    .cmpByteA (cmpByteA),
    .cmpByteB (cmpByteB)
  );

  hashTable i_hashTable (
    .clock     (clock),
    .arstN     (arstN),
    .clearAll  (clearAll),
    .window    (winBytes),
    .insert    (insert),
    .insertPos (curPos),
    .hit       (hit),
    .candidate (candidate)
  );

  matchComparator i_matchComparator (
    .clock    (clock),
    .arstN    (arstN),
    .start    (start),
    .curPos   (curPos),
    .candPos  (candPos),
    .blockLen (blockLen),
    .cmpByteA (cmpByteA),
    .cmpByteB (cmpByteB),
    .addrA    (addrA),
    .addrB    (addrB),
    .busy     (),
    .finished (finished),
    .matchLen (matchLen)
  );

  creditCounter i_creditCounter (
    .clock        (clock),
    .arstN        (arstN),
    .spend        (spend),
    .creditReturn (creditReturn),
    .haveCredit   (haveCredit)
  );

  matchController i_matchController (
    .clock        (clock),
    .arstN        (arstN),
    .inValid      (inValid),
    .inByte       (inByte),
    .inLast       (inLast),
    .curByte      (winBytes[0]),
    .hit          (hit),
    .candidate    (candidate),
    .finished     (finished),
    .matchLen     (matchLen),
    .haveCredit   (haveCredit),
    .inReady      (inReady),
    .wrEn         (wrEn),
    .wrAddr       (wrAddr),
    .wrData       (wrData),
    .curPos       (curPos),
    .insert       (insert),
    .clearAll     (clearAll),
    .start        (start),
    .candPos      (candPos),
    .blockLen     (blockLen),
    .spend        (spend),
    .tokenValid   (tokenValid),
    .tokenIsCopy  (tokenIsCopy),
    .tokenLiteral (tokenLiteral),
    .tokenOffset  (tokenOffset),
    .tokenLength  (tokenLength),
    .blockDone    (blockDone)
  );

endmodule

//--- dv/compressorTb.sv
`include "lz_macros.svh"

module compressorTb import lzPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ReadyLimit = 50;   // cycles to wait for inReady
  localparam int GapLimit   = 100;  // cycles with neither token nor blockDone
  localparam int BlockLimit = 3000; // cycles for a whole block

  logic       clock;
  logic       arstN;
  logic       inValid;
  logic [7:0] inByte;
  logic       inLast;
  logic       inReady;
  logic       tokenValid;
  logic       tokenIsCopy;
  logic [7:0] tokenLiteral;
  lzOffset_t  tokenOffset;
  lzLen_t     tokenLength;
  logic       creditReturn;
  logic       blockDone;

  logic [15:0] vecMem [256];   // vector words in hex
  logic [15:0] expKind [$];    // expected tokens of the running block
  logic [15:0] expVal [$];     // literal or offset
  logic [15:0] expLen [$];
  int          dueQ [$];       // cycles when credits go back
  integer      seed = 32'h2972;
  string       curName = "reset";
  int          errors = 0;
  int          tokensSeen = 0;
  int          returnsSent = 0;
  int          doneCount = 0;
  int          holdLeft = 0;   // consumer keeps credits while nonzero
  int          cycle = 0;
  int          lastDue = 0;
  int          testsRun = 0;
  int          testsFailed = 0;

  compressorTop i_compressorTop (
    .clock        (clock),
    .arstN        (arstN),
    .inValid      (inValid),
    .inByte       (inByte),
    .inLast       (inLast),
    .inReady      (inReady),
    .tokenValid   (tokenValid),
    .tokenIsCopy  (tokenIsCopy),
    .tokenLiteral (tokenLiteral),
    .tokenOffset  (tokenOffset),
    .tokenLength  (tokenLength),
    .creditReturn (creditReturn),
    .blockDone    (blockDone)
  );

  always #5 clock = ~clock; // 10 ns period

  function automatic string testName(input logic [15:0] code);
    case (code)
      16'h1:   return "literals";
      16'h2:   return "phrase";
      16'h3:   return "run";
      16'h4:   return "short";
      16'h5:   return "stall";
      16'h6:   return "blockA";
      16'h7:   return "blockB";
      default: return "unnamed";
    endcase
  endfunction

  task automatic timeoutStop(input string what);
    $display("%s: timeout, %s", curName, what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic reportTest(input int errBefore, input int nTok);
    testsRun++;
    if (errors != errBefore) begin
      testsFailed++;
    end
    $display("test %-8s %s, %0d tokens", curName,
             (errors == errBefore) ? "passed" : "failed", nTok);
  endtask

  // one token against the head of the expected list
  task automatic checkToken();
    logic [15:0] kind;
    logic [15:0] val;
    logic [15:0] len;
    assert (expKind.size() > 0) else begin
      errors++;
      $display("%s: token %0d came after the last expected token", curName, tokensSeen);
    end
    if (expKind.size() > 0) begin
      kind = expKind.pop_front();
      val  = expVal.pop_front();
      len  = expLen.pop_front();
      assert (tokenIsCopy == kind[0]) else begin
        errors++;
        $display("FAIL %s token %0d kind expected %0d actual %0d",
                 curName, tokensSeen, kind[0], tokenIsCopy);
      end
      if (kind[0]) begin
        assert (tokenOffset == val[7:0]) else begin
          errors++;
          $display("FAIL %s token %0d offset expected %0d actual %0d",
                   curName, tokensSeen, val[7:0], tokenOffset);
        end
      end else begin
        assert (tokenLiteral == val[7:0]) else begin
          errors++;
          $display("FAIL %s token %0d literal expected %h actual %h",
                   curName, tokensSeen, val[7:0], tokenLiteral);
        end
      end
      assert (tokenLength == len[3:0]) else begin
        errors++;
        $display("FAIL %s token %0d length expected %0d actual %0d",
                 curName, tokensSeen, len[3:0], tokenLength);
      end
    end
  endtask

  task automatic checkBlockEnd();
    assert (expKind.size() == 0) else begin
      errors++;
      $display("%s: blockDone came with %0d expected tokens missing", curName, expKind.size());
    end
    expKind.delete();
    expVal.delete();
    expLen.delete();
  endtask

  // consumer model sampling registered outputs on the falling edge
  always @(negedge clock) begin
    int dly;
    int due;
    cycle++;
    if (arstN && tokenValid) begin
      tokensSeen++;
      checkToken();
      assert (tokensSeen - returnsSent <= `LZ_CREDITS) else begin
        errors++;
        $display("%s: %0d tokens outstanding, more than the credits granted",
                 curName, tokensSeen - returnsSent);
      end
      dly = {$random(seed)} % 7; // 0..6 cycles consumer latency
      due = cycle + 1 + dly;
      if (due <= lastDue) begin
        due = lastDue + 1;       // at most one return per cycle in order
      end
      lastDue = due;
      dueQ.push_back(due);
    end
    if (arstN && blockDone) begin
      checkBlockEnd();
      doneCount++;
    end
    if (holdLeft > 0) begin
      holdLeft--;
    end
    if (holdLeft == 0 && dueQ.size() > 0 && dueQ[0] <= cycle) begin
      void'(dueQ.pop_front());
      returnsSent++;
      creditReturn = 1'b1;
    end else begin
      creditReturn = 1'b0;
    end
  end

  task automatic sendByte(input logic [7:0] b, input logic last);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!inReady && waited < ReadyLimit) begin
      @(negedge clock);
      waited++;
    end
    if (inReady) begin
      inValid = 1'b1;  // taken at the next rising edge
      inByte  = b;
      inLast  = last;
    end else begin
      timeoutStop("inReady stayed low while a byte was waiting");
    end
  endtask

  // gap timer restarts on every token
  task automatic waitBlockDone(input int target);
    int idle;
    int total;
    int lastSeen;
    idle     = 0;
    total    = 0;
    lastSeen = tokensSeen;
    while (doneCount < target && idle < GapLimit && total < BlockLimit) begin
      @(posedge clock);
      total++;
      if (tokensSeen != lastSeen) begin
        lastSeen = tokensSeen;
        idle     = 0;
      end else begin
        idle++;
      end
    end
    if (doneCount < target) begin
      timeoutStop("blockDone did not come in time");
    end
  endtask

  task automatic checkReset();
    int errBefore;
    errBefore = errors;
    @(negedge clock);
    assert (inReady === 1'b1) else begin
      errors++;
      $display("FAIL reset inReady expected 1 actual %b", inReady);
    end
    assert (tokenValid === 1'b0) else begin
      errors++;
      $display("FAIL reset tokenValid expected 0 actual %b", tokenValid);
    end
    assert (blockDone === 1'b0) else begin
      errors++;
      $display("FAIL reset blockDone expected 0 actual %b", blockDone);
    end
    assert ({tokenIsCopy, tokenLiteral, tokenOffset, tokenLength} === '0) else begin
      errors++;
      $display("FAIL reset token fields expected 0 actual %h",
               {tokenIsCopy, tokenLiteral, tokenOffset, tokenLength});
    end
    reportTest(errBefore, 0);
  endtask

  task automatic runBlock(inout int ptr);
    int         nBytes;
    int         nTok;
    int         target;
    int         errBefore;
    logic [7:0] blk [$];
    @(posedge clock); // set up away from the consumer's edge
    curName  = testName(vecMem[ptr]);
    nBytes   = vecMem[ptr+1];
    holdLeft = vecMem[ptr+2];
    for (int i = 0; i < nBytes; i++) begin
      blk.push_back(vecMem[ptr+3+i][7:0]);
    end
    ptr  = ptr + 3 + nBytes;
    nTok = vecMem[ptr];
    ptr++;
    for (int k = 0; k < nTok; k++) begin
      expKind.push_back(vecMem[ptr]);
      expVal.push_back(vecMem[ptr+1]);
      expLen.push_back(vecMem[ptr+2]);
      ptr = ptr + 3;
    end
    errBefore = errors;
    target    = doneCount + 1;
    for (int i = 0; i < nBytes; i++) begin
      sendByte(blk[i], i == nBytes - 1);
    end
    @(negedge clock);
    inValid = 1'b0;
    inLast  = 1'b0;
    waitBlockDone(target);
    reportTest(errBefore, nTok);
  endtask

  initial begin
    int ptr;
    int nTests;
    clock        = 1'b0;
    arstN        = 1'b0;
    inValid      = 1'b0;
    inByte       = '0;
    inLast       = 1'b0;
    creditReturn = 1'b0;
    $readmemh("dv/compressorVectors.txt", vecMem);
    repeat (5) @(posedge clock);
    @(negedge clock);
    arstN = 1'b1;
    checkReset();
    nTests = vecMem[0];
    ptr    = 1;
    assert (nTests > 0) else begin
      errors++;
      $display("vector file holds no tests");
    end
    for (int t = 0; t < nTests; t++) begin
      runBlock(ptr);
    end
    $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
rtl/lzPkg.sv
rtl/historyBuffer.sv
rtl/hashTable.sv
rtl/matchComparator.sv
rtl/creditCounter.sv
rtl/matchController.sv
rtl/compressorTop.sv
dv/compressorTb.sv

//--- dv/compressorVectors.txt
// word 0 is the test count; per test: name code, byte count, credit hold cycles,
// block bytes, token count, then per token: kind (0 literal 1 copy), literal or offset, length
// all values hex
7

// literals, no repeated three-byte group
1 5 0
10 20 30 40 50
5
0 10 1  0 20 1  0 30 1  0 40 1  0 50 1

// phrase, ABCD repeats at offset 4
2 9 0
41 42 43 44 41 42 43 44 45
6
0 41 1  0 42 1  0 43 1  0 44 1
1 4 4  0 45 1

// run, literal then copy capped at 15, then copy cut at block end
3 14 0
61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61 61
3
0 61 1  1 1 f  1 f 4

// short, xor collisions and a one-byte match, tail bytes literal
4 9 0
11 22 33 44 11 33 22 11 22
9
0 11 1  0 22 1  0 33 1  0 44 1  0 11 1
0 33 1  0 22 1  0 11 1  0 22 1

// stall, credits held back for 40 cycles
5 c 28
01 02 03 04 05 06 01 02 03 04 05 06
7
0 1 1  0 2 1  0 3 1  0 4 1  0 5 1  0 6 1
1 6 6

// blockA then blockB back to back, no shared history
6 5 0
41 42 43 44 45
5
0 41 1  0 42 1  0 43 1  0 44 1  0 45 1

7 5 0
43 44 45 41 42
5
0 43 1  0 44 1  0 45 1  0 41 1  0 42 1
